/* src/sar_macros.svh */
`ifndef SAR_MACROS_SVH
`define SAR_MACROS_SVH

// ---------------------------------------------------------------------------
// Reassembly cache dimensions
// ---------------------------------------------------------------------------

// Buffer id and byte offset widths
`define SAR_BUF_ID_W    4
`define SAR_OFFSET_W    16

// Fragment pointer width, 8 fragments in flight
`define SAR_FRAG_PTR_W  3

// Entries per lookup table
`define SAR_TABLE_DEPTH 8

// Pending deletes per table
`define SAR_DELQ_DEPTH  4

`endif

/* src/sar_pkg.sv */
`default_nettype none

package sar_pkg;

    `include "sar_macros.svh"

    // ------------------------------------------------------------------------
    // Width types
    // ------------------------------------------------------------------------
    typedef logic [`SAR_BUF_ID_W-1:0]   buf_id_t;
    typedef logic [`SAR_OFFSET_W-1:0]   offset_t;
    typedef logic [`SAR_FRAG_PTR_W-1:0] frag_ptr_t;

    // ------------------------------------------------------------------------
    // Records
    // ------------------------------------------------------------------------
    // Table key, a buffer plus one end of a fragment
    typedef struct packed {
        buf_id_t buf_id;
        offset_t offset;
    } table_key_t;

    // Table value, the fragment and its opposite end
    typedef struct packed {
        frag_ptr_t ptr;
        offset_t   offset;
    } table_value_t;

    // Segment as seen by the cache, end is offset plus length
    typedef struct packed {
        buf_id_t buf_id;
        offset_t offset_start;
        offset_t offset_end;
        logic    last;
    } seg_ctxt_t;

    // One write port request, insert or delete
    typedef struct packed {
        logic         req;
        logic         insert;
        table_key_t   key;
        table_value_t value;
    } table_wr_t;

    typedef struct packed {
        buf_id_t   buf_id;
        logic      init;
        logic      last;
        frag_ptr_t ptr;
        offset_t   offset_start;
        offset_t   offset_end;
        logic      merged;
        frag_ptr_t merged_ptr;
    } frag_rec_t;

    typedef enum logic [1:0] {
        FRAGMENT_CREATE,
        FRAGMENT_APPEND,
        FRAGMENT_PREPEND,
        FRAGMENT_MERGE
    } frag_action_t;

endpackage : sar_pkg

`default_nettype wire

/* src/sar_segment_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sar_macros.svh"

module sar_segment_table
    import sar_pkg::*;
(
    input  wire               clk,
    input  wire               __srst,

    // Lookup, result one cycle later
    input  wire table_key_t   i_lookup_key,
    output logic              o_hit,
    output table_value_t      o_value,

    // Insert or delete
    input  wire table_wr_t    i_wr,
    output logic              o_full
);

    localparam int DEPTH = `SAR_TABLE_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    logic [DEPTH-1:0] entry_valid;
    table_key_t       entry_key   [DEPTH];
    table_value_t     entry_value [DEPTH];

    logic [DEPTH-1:0] lookup_match;
    table_value_t     lookup_value;

    logic [DEPTH-1:0] wr_match;
    logic [IDX_W-1:0] match_idx;
    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic             ins_en;
    logic [IDX_W-1:0] ins_idx;

    // ------------------------------------------------------------------------
    // Parallel compare against all entries
    // ------------------------------------------------------------------------
    always_comb begin
        lookup_value = '0;
        for (int i = 0; i < DEPTH; i++) begin
            lookup_match[i] = entry_valid[i] && (entry_key[i] == i_lookup_key);
            wr_match[i]     = entry_valid[i] && (entry_key[i] == i_wr.key);
            // Keys are unique, at most one match
            if (lookup_match[i]) begin
                lookup_value = entry_value[i];
            end
        end
    end

    // Matching slot and lowest empty slot for the write port
    always_comb begin
        match_idx  = '0;
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (wr_match[i]) begin
                match_idx = IDX_W'(i);
            end
            if (!entry_valid[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    // Overwrite on a key match, else fill the lowest empty entry
    assign ins_en  = i_wr.req && i_wr.insert && ((|wr_match) || free_found);
    assign ins_idx = (|wr_match) ? match_idx : free_idx;

    assign o_full = &entry_valid;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            entry_valid <= '0;
            o_hit       <= 1'b0;
        end else begin
            o_hit <= |lookup_match;
            if (ins_en) begin
                entry_valid[ins_idx] <= 1'b1;
            end else if (i_wr.req && !i_wr.insert) begin
                entry_valid <= entry_valid & ~wr_match;
            end
        end
    end

    always_ff @(posedge clk) begin
        o_value <= lookup_value;
        if (ins_en) begin
            entry_key[ins_idx]   <= i_wr.key;
            entry_value[ins_idx] <= i_wr.value;
        end
    end

endmodule : sar_segment_table

`default_nettype wire

/* src/sar_frag_ptr_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sar_macros.svh"

module sar_frag_ptr_alloc
    import sar_pkg::*;
(
    input  wire            clk,
    input  wire            __srst,

    // Lowest free pointer, taken by a pulse on i_alloc
    output logic           o_free_valid,
    output frag_ptr_t      o_free_ptr,
    input  wire            i_alloc,

    // Pointer return
    input  wire            i_dealloc_valid,
    input  wire frag_ptr_t i_dealloc_ptr
);

    localparam int NUM_PTRS = 2 ** `SAR_FRAG_PTR_W;

    // One bit per pointer, set while in use
    logic [NUM_PTRS-1:0] busy;

    // ------------------------------------------------------------------------
    // Priority pick of the lowest free pointer
    // ------------------------------------------------------------------------
    always_comb begin
        o_free_valid = 1'b0;
        o_free_ptr   = '0;
        for (int i = NUM_PTRS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                o_free_valid = 1'b1;
                o_free_ptr   = frag_ptr_t'(i);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Busy vector update
    // ------------------------------------------------------------------------
    // Allocation and return in one cycle are both applied
    always_ff @(posedge clk) begin
        if (__srst) begin
            busy <= '0;
        end else begin
            if (i_alloc && o_free_valid) begin
                busy[o_free_ptr] <= 1'b1;
            end
            if (i_dealloc_valid) begin
                busy[i_dealloc_ptr] <= 1'b0;
            end
        end
    end

endmodule : sar_frag_ptr_alloc

`default_nettype wire

/* src/sar_delete_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sar_macros.svh"

module sar_delete_queue
    import sar_pkg::*;
(
    input  wire             clk,
    input  wire             __srst,

    input  wire             i_push,
    input  wire table_key_t i_push_key,

    // Head of queue, valid while not empty
    input  wire             i_pop,
    output table_key_t      o_key,

    output logic            o_empty,
    output logic            o_full
);

    localparam int DEPTH = `SAR_DELQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    table_key_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic do_push;
    logic do_pop;

    // A push into a full queue is lost
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_empty = (count == '0);
    assign o_full  = (count == (PTR_W + 1)'(DEPTH));
    assign o_key   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (__srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at the power of two depth
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_key;
        end
    end

endmodule : sar_delete_queue

`default_nettype wire

/* src/sar_fragment_resolver.sv */
`timescale 1ns/1ps
`default_nettype none

module sar_fragment_resolver
    import sar_pkg::*;
(
    input  wire               clk,
    input  wire               __srst,

    // Segment strobe
    input  wire               i_seg_valid,
    input  wire seg_ctxt_t    i_seg,

    // Table lookups
    output table_key_t        o_app_key,
    output table_key_t        o_pre_key,
    input  wire               i_app_hit,
    input  wire table_value_t i_app_value,
    input  wire               i_pre_hit,
    input  wire table_value_t i_pre_value,

    // Pointer allocation
    input  wire               i_free_valid,
    input  wire frag_ptr_t    i_free_ptr,
    output logic              o_alloc,

    // Table write ports
    output table_wr_t         o_app_wr,
    output table_wr_t         o_pre_wr,

    // Deletion queues
    output logic              o_app_del_push,
    output logic              o_pre_del_push,
    output table_key_t        o_del_key_app,
    output table_key_t        o_del_key_pre,
    input  wire               i_app_del_empty,
    input  wire               i_pre_del_empty,
    input  wire table_key_t   i_app_del_key,
    input  wire table_key_t   i_pre_del_key,
    output logic              o_app_del_pop,
    output logic              o_pre_del_pop,

    // Fragment result
    output logic              o_frag_valid,
    output frag_rec_t         o_frag,
    output logic              o_seg_dropped
);

    logic         lookup_vld;
    seg_ctxt_t    ctxt_q;

    frag_action_t action;
    frag_rec_t    frag;
    logic         frag_ok;

    logic         app_ins;
    logic         pre_ins;
    table_key_t   app_ins_key;
    table_key_t   pre_ins_key;

    // ------------------------------------------------------------------------
    // Lookup keys and segment context
    // ------------------------------------------------------------------------
    // Append side looks for a fragment ending where this segment starts
    assign o_app_key = '{buf_id: i_seg.buf_id, offset: i_seg.offset_start};
    assign o_pre_key = '{buf_id: i_seg.buf_id, offset: i_seg.offset_end};

    always_ff @(posedge clk) begin
        if (__srst) begin
            lookup_vld <= 1'b0;
        end else begin
            lookup_vld <= i_seg_valid;
        end
    end

    // Held alongside the table lookup
    always_ff @(posedge clk) begin
        if (i_seg_valid) begin
            ctxt_q <= i_seg;
        end
    end

    // ------------------------------------------------------------------------
    // Action decision
    // ------------------------------------------------------------------------
    always_comb begin
        case ({i_pre_hit, i_app_hit})
            2'b01:   action = FRAGMENT_APPEND;
            2'b10:   action = FRAGMENT_PREPEND;
            2'b11:   action = FRAGMENT_MERGE;
            default: action = FRAGMENT_CREATE;
        endcase
    end

    always_comb begin
        frag.buf_id       = ctxt_q.buf_id;
        frag.init         = (action == FRAGMENT_CREATE);
        frag.last         = ctxt_q.last;
        frag.offset_start = i_app_hit ? i_app_value.offset : ctxt_q.offset_start;
        frag.offset_end   = i_pre_hit ? i_pre_value.offset : ctxt_q.offset_end;
        frag.merged       = (action == FRAGMENT_MERGE);
        frag.merged_ptr   = frag.merged ? i_app_value.ptr : '0;
        // On a merge the upper fragment survives
        case (action)
            FRAGMENT_APPEND:  frag.ptr = i_app_value.ptr;
            FRAGMENT_PREPEND: frag.ptr = i_pre_value.ptr;
            FRAGMENT_MERGE:   frag.ptr = i_pre_value.ptr;
            default:          frag.ptr = i_free_ptr;
        endcase
    end

    // Create needs a free pointer
    assign frag_ok = lookup_vld && (!frag.init || i_free_valid);
    assign o_alloc = lookup_vld && frag.init && i_free_valid;

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            o_frag_valid  <= 1'b0;
            o_seg_dropped <= 1'b0;
        end else begin
            o_frag_valid  <= frag_ok;
            o_seg_dropped <= lookup_vld && frag.init && !i_free_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (frag_ok) begin
            o_frag <= frag;
        end
    end

    // ------------------------------------------------------------------------
    // Table updates
    // ------------------------------------------------------------------------
    // No append key past the last byte, no prepend key at offset zero
    assign app_ins = frag_ok && !ctxt_q.last;
    assign pre_ins = frag_ok && (frag.offset_start != '0);

    assign app_ins_key = '{buf_id: ctxt_q.buf_id, offset: frag.offset_end};
    assign pre_ins_key = '{buf_id: ctxt_q.buf_id, offset: frag.offset_start};

    // Port idle this cycle, drain one stale key
    assign o_app_del_pop = !app_ins && !i_app_del_empty;
    assign o_pre_del_pop = !pre_ins && !i_pre_del_empty;

    always_comb begin
        o_app_wr.req    = app_ins || o_app_del_pop;
        o_app_wr.insert = app_ins;
        o_app_wr.key    = app_ins ? app_ins_key : i_app_del_key;
        o_app_wr.value  = '{ptr: frag.ptr, offset: frag.offset_start};

        o_pre_wr.req    = pre_ins || o_pre_del_pop;
        o_pre_wr.insert = pre_ins;
        o_pre_wr.key    = pre_ins ? pre_ins_key : i_pre_del_key;
        o_pre_wr.value  = '{ptr: frag.ptr, offset: frag.offset_end};
    end

    // Keys consumed by the segment become stale
    assign o_app_del_push = frag_ok &&
                            (action == FRAGMENT_APPEND || action == FRAGMENT_MERGE);
    assign o_pre_del_push = frag_ok &&
                            (action == FRAGMENT_PREPEND || action == FRAGMENT_MERGE);

    assign o_del_key_app = '{buf_id: ctxt_q.buf_id, offset: ctxt_q.offset_start};
    assign o_del_key_pre = '{buf_id: ctxt_q.buf_id, offset: ctxt_q.offset_end};

endmodule : sar_fragment_resolver

`default_nettype wire

/* src/sar_reassembly_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module sar_reassembly_cache
    import sar_pkg::*;
(
    input  wire            clk,
    input  wire            __srst,

    // Segment strobe, no back-pressure
    input  wire            i_seg_valid,
    input  wire seg_ctxt_t i_seg,

    // Fragment result
    output logic           o_frag_valid,
    output frag_rec_t      o_frag,
    output logic           o_seg_dropped,

    // Pointer return
    input  wire            i_dealloc_valid,
    input  wire frag_ptr_t i_dealloc_ptr
);

    table_key_t   app_key;
    table_key_t   pre_key;
    logic         app_hit;
    logic         pre_hit;
    table_value_t app_value;
    table_value_t pre_value;
    table_wr_t    app_wr;
    table_wr_t    pre_wr;

    logic         free_valid;
    frag_ptr_t    free_ptr;
    logic         alloc;

    logic         app_del_push;
    logic         pre_del_push;
    table_key_t   app_del_push_key;
    table_key_t   pre_del_push_key;
    logic         app_del_pop;
    logic         pre_del_pop;
    table_key_t   app_del_key;
    table_key_t   pre_del_key;
    logic         app_delq_empty;
    logic         pre_delq_empty;
    logic         app_delq_full;
    logic         pre_delq_full;

    // ------------------------------------------------------------------------
    // Lookup tables
    // ------------------------------------------------------------------------
    // Keyed by fragment end
    sar_segment_table u_app_table (
        .clk          (clk),
        .__srst       (__srst),
        .i_lookup_key (app_key),
        .o_hit        (app_hit),
        .o_value      (app_value),
        .i_wr         (app_wr),
        .o_full       ()
    );

    // Keyed by fragment start
    sar_segment_table u_pre_table (
        .clk          (clk),
        .__srst       (__srst),
        .i_lookup_key (pre_key),
        .o_hit        (pre_hit),
        .o_value      (pre_value),
        .i_wr         (pre_wr),
        .o_full       ()
    );

    // ------------------------------------------------------------------------
    // Pointer allocator and deletion queues
    // ------------------------------------------------------------------------
    sar_frag_ptr_alloc u_ptr_alloc (
        .clk             (clk),
        .__srst          (__srst),
        .o_free_valid    (free_valid),
        .o_free_ptr      (free_ptr),
        .i_alloc         (alloc),
        .i_dealloc_valid (i_dealloc_valid),
        .i_dealloc_ptr   (i_dealloc_ptr)
    );

    sar_delete_queue u_app_delq (
        .clk        (clk),
        .__srst     (__srst),
        .i_push     (app_del_push),
        .i_push_key (app_del_push_key),
        .i_pop      (app_del_pop),
        .o_key      (app_del_key),
        .o_empty    (app_delq_empty),
        .o_full     (app_delq_full)
    );

    sar_delete_queue u_pre_delq (
        .clk        (clk),
        .__srst     (__srst),
        .i_push     (pre_del_push),
        .i_push_key (pre_del_push_key),
        .i_pop      (pre_del_pop),
        .o_key      (pre_del_key),
        .o_empty    (pre_delq_empty),
        .o_full     (pre_delq_full)
    );

    // ------------------------------------------------------------------------
    // Decision and update logic
    // ------------------------------------------------------------------------
    sar_fragment_resolver u_resolver (
        .clk             (clk),
        .__srst          (__srst),
        .i_seg_valid     (i_seg_valid),
        .i_seg           (i_seg),
        .o_app_key       (app_key),
        .o_pre_key       (pre_key),
        .i_app_hit       (app_hit),
        .i_app_value     (app_value),
        .i_pre_hit       (pre_hit),
        .i_pre_value     (pre_value),
        .i_free_valid    (free_valid),
        .i_free_ptr      (free_ptr),
        .o_alloc         (alloc),
        .o_app_wr        (app_wr),
        .o_pre_wr        (pre_wr),
        .o_app_del_push  (app_del_push),
        .o_pre_del_push  (pre_del_push),
        .o_del_key_app   (app_del_push_key),
        .o_del_key_pre   (pre_del_push_key),
        .i_app_del_empty (app_delq_empty),
        .i_pre_del_empty (pre_delq_empty),
        .i_app_del_key   (app_del_key),
        .i_pre_del_key   (pre_del_key),
        .o_app_del_pop   (app_del_pop),
        .o_pre_del_pop   (pre_del_pop),
        .o_frag_valid    (o_frag_valid),
        .o_frag          (o_frag),
        .o_seg_dropped   (o_seg_dropped)
    );

endmodule : sar_reassembly_cache

`default_nettype wire

/* tests/sar_reassembly_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module sar_reassembly_assertions (
    input wire clk,
    input wire __srst,
    input wire i_frag_valid,
    input wire i_seg_dropped,
    input wire i_app_del_push,
    input wire i_app_delq_full,
    input wire i_pre_del_push,
    input wire i_pre_delq_full
);

    int reset_fails    = 0;
    int app_full_fails = 0;
    int pre_full_fails = 0;
    int excl_fails     = 0;
    int failures;

    assign failures = reset_fails + app_full_fails + pre_full_fails + excl_fails;

    // ------------------------------------------------------------------------
    // Protocol checks on the top level
    // ------------------------------------------------------------------------
    // Result strobes held low through reset
    reset_quiet: assert property (@(posedge clk)
        __srst |=> (!i_frag_valid && !i_seg_dropped))
        else begin
            $error("result strobe raised during reset");
            reset_fails++;
        end

    // A stale key pushed into a full queue would be lost
    app_delq_room: assert property (@(posedge clk) disable iff (__srst)
        !(i_app_del_push && i_app_delq_full))
        else begin
            $error("delete pushed into full append queue");
            app_full_fails++;
        end

    pre_delq_room: assert property (@(posedge clk) disable iff (__srst)
        !(i_pre_del_push && i_pre_delq_full))
        else begin
            $error("delete pushed into full prepend queue");
            pre_full_fails++;
        end

    // One segment gives a record or a drop, never both
    result_exclusive: assert property (@(posedge clk) disable iff (__srst)
        !(i_frag_valid && i_seg_dropped))
        else begin
            $error("record and drop strobes high together");
            excl_fails++;
        end

endmodule : sar_reassembly_assertions

bind sar_reassembly_cache sar_reassembly_assertions u_protocol_checks (
    .clk             (clk),
    .__srst          (__srst),
    .i_frag_valid    (o_frag_valid),
    .i_seg_dropped   (o_seg_dropped),
    .i_app_del_push  (app_del_push),
    .i_app_delq_full (app_delq_full),
    .i_pre_del_push  (pre_del_push),
    .i_pre_delq_full (pre_delq_full)
);

`default_nettype wire

/* tests/tb_sar_reassembly_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sar_macros.svh"

module tb_sar_reassembly_cache
    import sar_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_PTRS     = 2 ** `SAR_FRAG_PTR_W;
    localparam int RESP_TIMEOUT = 10;
    // Generous bound on segments and cycles spent per segment
    localparam int MAX_SEGMENTS = 200;
    localparam int SEG_CYCLES   = 12;
    localparam int WATCHDOG_NS  = (MAX_SEGMENTS * SEG_CYCLES + 100) * CLK_PERIOD;

    logic      clk;
    logic      __srst;
    logic      i_seg_valid;
    seg_ctxt_t i_seg;
    logic      o_frag_valid;
    frag_rec_t o_frag;
    logic      o_seg_dropped;
    logic      i_dealloc_valid;
    frag_ptr_t i_dealloc_ptr;

    // Reference fragments, indexed by pointer
    logic    live       [NUM_PTRS];
    buf_id_t frag_buf   [NUM_PTRS];
    offset_t frag_start [NUM_PTRS];
    offset_t frag_end   [NUM_PTRS];

    logic [31:0] lfsr_state    = 32'hee54_73dc;
    int          checks        = 0;
    int          errors        = 0;
    int          errors_before = 0;
    int          tests_run     = 0;

    sar_reassembly_cache DUT (
        .clk             (clk),
        .__srst          (__srst),
        .i_seg_valid     (i_seg_valid),
        .i_seg           (i_seg),
        .o_frag_valid    (o_frag_valid),
        .o_frag          (o_frag),
        .o_seg_dropped   (o_seg_dropped),
        .i_dealloc_valid (i_dealloc_valid),
        .i_dealloc_ptr   (i_dealloc_ptr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic offset_t rand_len();
        return offset_t'(1 + rand_bits(4));
    endfunction

    // Lowest pointer not held by a reference fragment
    function automatic logic find_free(output frag_ptr_t ptr);
        logic found;
        found = 1'b0;
        ptr   = '0;
        for (int p = 0; p < NUM_PTRS; p++) begin
            if (!found && !live[p]) begin
                found = 1'b1;
                ptr   = frag_ptr_t'(p);
            end
        end
        return found;
    endfunction

    task automatic expect_equal(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic release_pointer(input frag_ptr_t p);
        i_dealloc_valid = 1'b1;
        i_dealloc_ptr   = p;
        idle(1);
        i_dealloc_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("[%0t ns] test %s finished, %0d errors", $time, name, errors - errors_before);
        errors_before = errors;
    endtask

    // Strobe one segment, latency in cycles or 0 when nothing came back
    task automatic send_segment(input buf_id_t b, input offset_t s, input offset_t e,
                                input logic l, output int lat);
        i_seg_valid = 1'b1;
        i_seg       = '{buf_id: b, offset_start: s, offset_end: e, last: l};
        idle(1);
        i_seg_valid = 1'b0;
        lat = 1;
        while (!o_frag_valid && !o_seg_dropped && lat < RESP_TIMEOUT) begin
            idle(1);
            lat++;
        end
        if (!o_frag_valid && !o_seg_dropped) begin
            $display("No response to segment [%0d, %0d) of buffer %0d", s, e, b);
            errors++;
            lat = 0;
        end
    endtask

    // Send a segment and check the record against the reference fragments
    task automatic apply_segment(input buf_id_t b, input offset_t s, input offset_t e,
                                 input logic l);
        logic      app_hit;
        logic      pre_hit;
        logic      have_free;
        frag_ptr_t app_ptr;
        frag_ptr_t pre_ptr;
        frag_ptr_t free_ptr;
        frag_ptr_t exp_ptr;
        offset_t   exp_start;
        offset_t   exp_end;
        int        lat;

        app_hit = 1'b0;
        pre_hit = 1'b0;
        app_ptr = '0;
        pre_ptr = '0;
        for (int p = 0; p < NUM_PTRS; p++) begin
            if (live[p] && frag_buf[p] == b && frag_end[p] == s) begin
                app_hit = 1'b1;
                app_ptr = frag_ptr_t'(p);
            end
            if (live[p] && frag_buf[p] == b && frag_start[p] == e) begin
                pre_hit = 1'b1;
                pre_ptr = frag_ptr_t'(p);
            end
        end
        have_free = find_free(free_ptr);
        exp_start = app_hit ? frag_start[app_ptr] : s;
        exp_end   = pre_hit ? frag_end[pre_ptr] : e;
        exp_ptr   = pre_hit ? pre_ptr : (app_hit ? app_ptr : free_ptr);

        send_segment(b, s, e, l, lat);
        if (lat != 0) begin
            expect_equal("latency", lat, 2);
            if (!app_hit && !pre_hit && !have_free) begin
                expect_equal("o_seg_dropped", int'(o_seg_dropped), 1);
                expect_equal("o_frag_valid", int'(o_frag_valid), 0);
            end else begin
                expect_equal("o_frag_valid", int'(o_frag_valid), 1);
                expect_equal("o_frag.buf_id", int'(o_frag.buf_id), int'(b));
                expect_equal("o_frag.init", int'(o_frag.init), int'(!app_hit && !pre_hit));
                expect_equal("o_frag.last", int'(o_frag.last), int'(l));
                expect_equal("o_frag.ptr", int'(o_frag.ptr), int'(exp_ptr));
                expect_equal("o_frag.offset_start", int'(o_frag.offset_start),
                             int'(exp_start));
                expect_equal("o_frag.offset_end", int'(o_frag.offset_end), int'(exp_end));
                expect_equal("o_frag.merged", int'(o_frag.merged), int'(app_hit && pre_hit));
                live[exp_ptr]       = 1'b1;
                frag_buf[exp_ptr]   = b;
                frag_start[exp_ptr] = exp_start;
                frag_end[exp_ptr]   = exp_end;
                // Lower fragment is absorbed, its pointer goes back
                if (app_hit && pre_hit) begin
                    expect_equal("o_frag.merged_ptr", int'(o_frag.merged_ptr), int'(app_ptr));
                    live[app_ptr] = 1'b0;
                    release_pointer(app_ptr);
                end
            end
        end
        idle(2);
    endtask

    // Split a span into 4 to 7 segments and send them shuffled
    task automatic reassemble(input buf_id_t b, input offset_t base);
        offset_t cut   [8];
        int      order [7];
        int      num;
        int      j;
        int      tmp;

        num    = 4 + rand_bits(2);
        cut[0] = base;
        for (int i = 0; i < num; i++) begin
            cut[i + 1] = cut[i] + rand_len();
            order[i]   = i;
        end
        for (int i = num - 1; i > 0; i--) begin
            j        = rand_bits(3) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        // Only the segment holding the final byte is marked last
        for (int i = 0; i < num; i++) begin
            apply_segment(b, cut[order[i]], cut[order[i] + 1], order[i] == num - 1);
        end
        expect_equal("reassembled start", int'(o_frag.offset_start), int'(cut[0]));
        expect_equal("reassembled end", int'(o_frag.offset_end), int'(cut[num]));
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        buf_id_t   b0;
        offset_t   base;
        offset_t   e1;
        offset_t   e2;
        offset_t   gap;
        frag_ptr_t free_ptr;
        frag_ptr_t victim;
        logic      have_free;
        int        n;

        i_seg_valid     = 1'b0;
        i_seg           = '0;
        i_dealloc_valid = 1'b0;
        i_dealloc_ptr   = '0;
        for (int p = 0; p < NUM_PTRS; p++) begin
            live[p] = 1'b0;
        end
        __srst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        __srst = 1'b0;

        for (int i = 0; i < 8; i++) begin
            expect_equal("o_frag_valid", int'(o_frag_valid), 0);
            expect_equal("o_seg_dropped", int'(o_seg_dropped), 0);
            idle(1);
        end
        finish_test("reset_idle");

        b0   = buf_id_t'(rand_bits(4));
        base = offset_t'(16 + rand_bits(6));
        e1   = base + rand_len();
        apply_segment(b0, base, e1, 1'b0);
        finish_test("create");
        e2 = e1 + rand_len();
        apply_segment(b0, e1, e2, 1'b0);
        finish_test("append");
        apply_segment(b0, base - rand_len(), base, 1'b0);
        finish_test("prepend");
        // Upper fragment first, then the gap below it
        gap = rand_len();
        apply_segment(b0, e2 + gap, e2 + gap + rand_len(), 1'b0);
        apply_segment(b0, e2, e2 + gap, 1'b0);
        finish_test("merge");

        reassemble(b0 + 4'd1, '0);
        reassemble(b0 + 4'd2, offset_t'(256 + rand_bits(8)));
        finish_test("random_order");

        // Use up every pointer with isolated creates
        n         = 0;
        have_free = find_free(free_ptr);
        while (have_free && n < NUM_PTRS) begin
            apply_segment(b0 + 4'd3, offset_t'(64 * n + 8),
                          offset_t'(64 * n + 8) + rand_len(), 1'b0);
            n++;
            have_free = find_free(free_ptr);
        end
        apply_segment(b0 + 4'd3, 16'd3000, 16'd3010, 1'b0);
        victim       = frag_ptr_t'(rand_bits(3));
        live[victim] = 1'b0;
        release_pointer(victim);
        idle(1);
        apply_segment(b0 + 4'd3, 16'd4000, 16'd4012, 1'b0);
        expect_equal("returned pointer", int'(o_frag.ptr), int'(victim));
        finish_test("exhaust");

        $display("%0d tests, %0d checks, %0d errors, %0d protocol assertion failures",
                 tests_run, checks, errors, DUT.u_protocol_checks.failures);
        if (errors == 0 && DUT.u_protocol_checks.failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_sar_reassembly_cache

`default_nettype wire

/* compile.f */
+incdir+src
src/sar_pkg.sv
src/sar_segment_table.sv
src/sar_frag_ptr_alloc.sv
src/sar_delete_queue.sv
src/sar_fragment_resolver.sv
src/sar_reassembly_cache.sv
tests/sar_reassembly_assertions.sv
tests/tb_sar_reassembly_cache.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_sar_reassembly_cache
FILELIST   ?= compile.f
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
RUN_FLAGS  ?= +verilator+error+limit+100
OBJ_DIR    ?= obj_dir
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
